// File: all.f
+incdir+src
src/isa_pkg.sv
src/ctrl_pkg.sv
src/instr_decode.sv
src/serial_alu.sv
src/reg_file.sv
src/pc_ctrl.sv
src/store_unit.sv
src/bitcore_top.sv
bench/bitcore_assertions.sv
bench/tb_bitcore.sv

// File: bench/bitcore_assertions.sv
`timescale 1ns/100ps

module bitcore_assertions (
   input logic       clk,
   input logic       i_rst_n,
   input logic       i_ibus_cyc,
   input logic       i_ibus_ack,
   input logic       i_dbus_cyc,
   input logic       i_dbus_ack,
   input logic [4:0] i_cnt,
   input logic       i_cnt_en
);

   // Fetch and store never overlap
   bus_exclusive: assert property (@(posedge clk) disable iff (!i_rst_n)
      !(i_ibus_cyc && i_dbus_cyc))
      else $error("instruction and data bus requests are active together");

   ibus_held: assert property (@(posedge clk) disable iff (!i_rst_n)
      i_ibus_cyc && !i_ibus_ack |=> i_ibus_cyc)
      else $error("instruction bus request dropped before its ack");

   dbus_held: assert property (@(posedge clk) disable iff (!i_rst_n)
      i_dbus_cyc && !i_dbus_ack |=> i_dbus_cyc)
      else $error("data bus request dropped before its ack");

   // Bit index walks 0 to 31 without gaps
   cnt_step: assert property (@(posedge clk) disable iff (!i_rst_n)
      i_cnt_en && (i_cnt != 5'd31) |=> i_cnt_en && (i_cnt == $past(i_cnt) + 5'd1))
      else $error("bit counter did not advance by one during execute");

endmodule

// File: bench/tb_bitcore.sv
`timescale 1ns/100ps
`include "core_defines.svh"

module tb_bitcore;

   localparam int PROG_WORDS = 128;
   localparam int RAND_COUNT = 60;

   logic        clk;
   logic        i_rst_n;
   logic [31:0] o_ibus_adr;
   logic        o_ibus_cyc;
   logic [31:0] i_ibus_rdt;
   logic        i_ibus_ack;
   logic [31:0] o_dbus_adr;
   logic [31:0] o_dbus_dat;
   logic        o_dbus_cyc;
   logic        i_dbus_ack;

   logic [31:0] prog [PROG_WORDS];
   string       prog_name [PROG_WORDS];
   int          prog_len;
   logic [31:0] ref_regs [`CORE_NREGS];
   logic [31:0] exp_adr [$];
   logic [31:0] exp_dat [$];
   string       exp_name [$];
   logic [31:0] rng_state;
   int          mismatches;
   int          other_errors;
   int          fetches;
   int          cycles;
   int          cycle_limit;
   int          ibus_wait;
   int          dbus_wait;
   bit          timed_out;

   bitcore_top UUT (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .o_ibus_adr (o_ibus_adr),
      .o_ibus_cyc (o_ibus_cyc),
      .i_ibus_rdt (i_ibus_rdt),
      .i_ibus_ack (i_ibus_ack),
      .o_dbus_adr (o_dbus_adr),
      .o_dbus_dat (o_dbus_dat),
      .o_dbus_cyc (o_dbus_cyc),
      .i_dbus_ack (i_dbus_ack)
   );

   bind bitcore_top bitcore_assertions u_assertions (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_ibus_cyc (o_ibus_cyc),
      .i_ibus_ack (i_ibus_ack),
      .i_dbus_cyc (o_dbus_cyc),
      .i_dbus_ack (i_dbus_ack),
      .i_cnt      (cnt),
      .i_cnt_en   (cnt_en)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   function automatic logic [31:0] next_random();
      logic [31:0] x;
      x = rng_state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rng_state = x;
      return x;
   endfunction

   function automatic logic [31:0] enc_lui(logic [4:0] rd, logic [19:0] imm);
      return {imm, rd, isa_pkg::OP_LUI};
   endfunction

   function automatic logic [31:0] enc_imm(logic [2:0] f3, logic [4:0] rd, logic [4:0] rs1,
                                           logic [11:0] imm);
      return {imm, rs1, f3, rd, isa_pkg::OP_IMM};
   endfunction

   function automatic logic [31:0] enc_reg(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd,
                                           logic [4:0] rs1, logic [4:0] rs2);
      return {f7, rs2, rs1, f3, rd, isa_pkg::OP_REG};
   endfunction

   function automatic logic [31:0] enc_sw(logic [4:0] rs2, logic [4:0] rs1, logic [11:0] imm);
      return {imm[11:5], rs2, rs1, isa_pkg::F3_SW, imm[4:0], isa_pkg::OP_STORE};
   endfunction

   // Mix of legal ops, odd funct fields and raw words, on x0..x7
   function automatic logic [31:0] random_instr();
      logic [31:0] r;
      logic [31:0] s;
      logic [6:0]  f7;
      logic [2:0]  f3;
      r  = next_random();
      s  = next_random();
      f7 = s[15] ? 7'b0100000 : (s[16] ? s[23:17] : 7'b0000000);
      f3 = s[12] ? isa_pkg::F3_SW : s[15:13];
      case (r[31:29])
         3'd0:       return enc_lui({2'b00, r[2:0]}, s[19:0]);
         3'd1, 3'd2: return enc_imm(s[14:12], {2'b00, r[2:0]}, {2'b00, r[5:3]}, s[11:0]);
         3'd3, 3'd4: return enc_reg(f7, s[14:12], {2'b00, r[2:0]}, {2'b00, r[5:3]},
                                    {2'b00, r[8:6]});
         3'd5, 3'd6: return {s[11:5], 2'b00, r[8:6], 2'b00, r[5:3], f3, s[4:0],
                             isa_pkg::OP_STORE};
         default:    return s;
      endcase
   endfunction

   task automatic add_instr(input string name, input logic [31:0] word);
      prog[prog_len]      = word;
      prog_name[prog_len] = name;
      prog_len++;
   endtask

   task automatic build_program();
      int r;
      prog_len = 0;
      add_instr("lui_store", enc_lui(5'd1, 20'habcde));
      add_instr("lui_store", enc_sw(5'd1, 5'd0, 12'h000));
      add_instr("lui_store", enc_lui(5'd2, 20'h80001));
      add_instr("lui_store", enc_sw(5'd2, 5'd0, 12'h004));
      // Negative immediates, then carries through all 32 bits
      add_instr("add_sub", enc_imm(isa_pkg::F3_ADD, 5'd3, 5'd0, 12'hfff));
      add_instr("add_sub", enc_imm(isa_pkg::F3_ADD, 5'd4, 5'd0, 12'h800));
      add_instr("add_sub", enc_reg(7'h00, isa_pkg::F3_ADD, 5'd5, 5'd3, 5'd3));
      add_instr("add_sub", enc_lui(5'd6, 20'h7ffff));
      add_instr("add_sub", enc_imm(isa_pkg::F3_ADD, 5'd6, 5'd6, 12'h7ff));
      add_instr("add_sub", enc_reg(7'h00, isa_pkg::F3_ADD, 5'd7, 5'd6, 5'd3));
      add_instr("add_sub", enc_reg(7'h20, isa_pkg::F3_ADD, 5'd8, 5'd0, 5'd3));
      add_instr("add_sub", enc_reg(7'h20, isa_pkg::F3_ADD, 5'd9, 5'd4, 5'd6));
      add_instr("add_sub", enc_imm(isa_pkg::F3_ADD, 5'd10, 5'd3, 12'h001));
      for (r = 3; r <= 10; r++) begin
         add_instr("add_sub", enc_sw(5'(r), 5'd0, 12'(4 * r)));
      end
      add_instr("logic_ops", enc_lui(5'd11, 20'hf0f0f));
      add_instr("logic_ops", enc_imm(isa_pkg::F3_OR, 5'd11, 5'd11, 12'h0f0));
      add_instr("logic_ops", enc_reg(7'h00, isa_pkg::F3_XOR, 5'd12, 5'd11, 5'd6));
      add_instr("logic_ops", enc_reg(7'h00, isa_pkg::F3_OR, 5'd13, 5'd11, 5'd4));
      add_instr("logic_ops", enc_reg(7'h00, isa_pkg::F3_AND, 5'd14, 5'd11, 5'd9));
      add_instr("logic_ops", enc_imm(isa_pkg::F3_XOR, 5'd15, 5'd11, 12'hfff));
      add_instr("logic_ops", enc_imm(isa_pkg::F3_OR, 5'd16, 5'd0, 12'h800));
      add_instr("logic_ops", enc_imm(isa_pkg::F3_AND, 5'd17, 5'd11, 12'hff0));
      for (r = 11; r <= 17; r++) begin
         add_instr("logic_ops", enc_sw(5'(r), 5'd0, 12'(4 * r)));
      end
      add_instr("x0_store", enc_imm(isa_pkg::F3_ADD, 5'd0, 5'd3, 12'h005));
      add_instr("x0_store", enc_reg(7'h00, isa_pkg::F3_OR, 5'd0, 5'd6, 5'd11));
      add_instr("x0_store", enc_sw(5'd0, 5'd6, 12'hffc));
      add_instr("x0_store", enc_sw(5'd0, 5'd6, 12'h007));
      for (r = 0; r < RAND_COUNT; r++) begin
         add_instr("random", random_instr());
      end
      // Flush what the random run left in x1..x7
      for (r = 1; r < 8; r++) begin
         add_instr("random", enc_sw(5'(r), 5'd0, 12'(4 * r)));
      end
   endtask

   // Runs the whole program on a register model and queues the stores
   function automatic void run_reference();
      logic [31:0] w;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] res;
      logic [6:0]  f7;
      bit          wr;
      for (int i = 0; i < `CORE_NREGS; i++) begin
         ref_regs[i] = 32'd0;
      end
      for (int n = 0; n < prog_len; n++) begin
         w   = prog[n];
         f7  = w[31:25];
         a   = ref_regs[w[19:15]];
         b   = ref_regs[w[24:20]];
         wr  = 1'b0;
         res = 32'd0;
         if (w[6:0] == isa_pkg::OP_LUI) begin
            res = {w[31:12], 12'd0};
            wr  = 1'b1;
         end else if (w[6:0] == isa_pkg::OP_IMM) begin
            b  = {{20{w[31]}}, w[31:20]};
            wr = 1'b1;
            case (w[14:12])
               isa_pkg::F3_ADD: res = a + b;
               isa_pkg::F3_XOR: res = a ^ b;
               isa_pkg::F3_OR:  res = a | b;
               isa_pkg::F3_AND: res = a & b;
               default:         wr = 1'b0;
            endcase
         end else if (w[6:0] == isa_pkg::OP_REG) begin
            wr = (f7 == 7'b0000000);
            case (w[14:12])
               isa_pkg::F3_ADD: begin
                  res = (f7 == 7'b0100000) ? a - b : a + b;
                  wr  = wr || (f7 == 7'b0100000);
               end
               isa_pkg::F3_XOR: res = a ^ b;
               isa_pkg::F3_OR:  res = a | b;
               isa_pkg::F3_AND: res = a & b;
               default:         wr = 1'b0;
            endcase
         end else if (w[6:0] == isa_pkg::OP_STORE && w[14:12] == isa_pkg::F3_SW) begin
            res = a + {{20{w[31]}}, w[31:25], w[11:7]};
            exp_adr.push_back({res[31:2], 2'b00});
            exp_dat.push_back(b);
            exp_name.push_back(prog_name[n]);
         end
         if (wr && w[11:7] != 5'd0) begin
            ref_regs[w[11:7]] = res;
         end
      end
   endfunction

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (actual !== expected) begin
         mismatches++;
         $display("MISMATCH %s: expected %08h, actual %08h", name, expected, actual);
      end
   endtask

   // Memory model for both buses, with 0 to 3 wait cycles per request
   always @(posedge clk) begin
      int word_idx;
      if (!i_rst_n) begin
         i_ibus_ack <= 1'b0;
         i_dbus_ack <= 1'b0;
      end else begin
         if (i_ibus_ack) begin
            i_ibus_ack <= 1'b0;
         end else if (o_ibus_cyc) begin
            if (ibus_wait == 0) begin
               word_idx = int'(o_ibus_adr[31:2]);
               if (word_idx < prog_len) begin
                  i_ibus_rdt <= prog[word_idx];
               end else begin
                  i_ibus_rdt <= {o_ibus_adr[31:7] ^ o_ibus_adr[24:0], 7'b0000000};
               end
               i_ibus_ack <= 1'b1;
               ibus_wait = int'(next_random() & 32'd3);
            end else begin
               ibus_wait--;
            end
         end
         if (i_dbus_ack) begin
            i_dbus_ack <= 1'b0;
         end else if (o_dbus_cyc) begin
            if (dbus_wait == 0) begin
               i_dbus_ack <= 1'b1;
               dbus_wait = int'(next_random() & 32'd3);
            end else begin
               dbus_wait--;
            end
         end
      end
   end

   // Compare process, sampled on the edge where a bus transfer completes
   always @(posedge clk) begin
      string name;
      if (i_rst_n && !timed_out) begin
         cycles++;
         if (cycles >= cycle_limit) begin
            timed_out = 1'b1;
         end
         if (o_ibus_cyc && i_ibus_ack) begin
            check_value("fetch_address", `CORE_RESET_PC + 32'(fetches * 4), o_ibus_adr);
            fetches++;
         end
         if (o_dbus_cyc && i_dbus_ack) begin
            if (exp_adr.size() == 0) begin
               other_errors++;
               $display("Unexpected store to %08h with data %08h", o_dbus_adr, o_dbus_dat);
            end else begin
               name = exp_name.pop_front();
               check_value({name, "_address"}, exp_adr.pop_front(), o_dbus_adr);
               check_value({name, "_data"}, exp_dat.pop_front(), o_dbus_dat);
            end
         end
      end
   end

   initial begin
      i_rst_n      = 1'b0;
      i_ibus_rdt   = 32'd0;
      i_ibus_ack   = 1'b0;
      i_dbus_ack   = 1'b0;
      rng_state    = 32'd59046;
      mismatches   = 0;
      other_errors = 0;
      fetches      = 0;
      cycles       = 0;
      timed_out    = 1'b0;
      build_program();
      run_reference();
      // Worst case is about 34 cycles plus two waits of 4 per instruction
      cycle_limit = 60 * (prog_len + 1) + 200;
      ibus_wait   = int'(next_random() & 32'd3);
      dbus_wait   = int'(next_random() & 32'd3);
      repeat (8) @(posedge clk);
      i_rst_n <= 1'b1;
      wait (fetches > prog_len || timed_out);
      if (timed_out) begin
         other_errors++;
         $display("Timeout: only %0d of %0d fetches done after %0d cycles",
                  fetches, prog_len + 1, cycles);
      end else if (exp_adr.size() != 0) begin
         other_errors++;
         $display("%0d expected stores never reached the data bus", exp_adr.size());
      end
      $display("Errors: %0d mismatches, %0d other failures", mismatches, other_errors);
      if (mismatches == 0 && other_errors == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_bitcore \
   -f all.f -o sim_bitcore

status=0
./obj_dir/sim_bitcore > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Test failures found" sim.log; then
   echo "Simulation FAILED"
   exit 1
fi
echo "Simulation passed"

// File: src/bitcore_top.sv
`timescale 1ns/100ps
`include "core_defines.svh"

module bitcore_top (
   input  logic                  clk,
   input  logic                  i_rst_n,
   output logic [`CORE_XLEN-1:0] o_ibus_adr,
   output logic                  o_ibus_cyc,
   input  logic [`CORE_XLEN-1:0] i_ibus_rdt,
   input  logic                  i_ibus_ack,
   output logic [`CORE_XLEN-1:0] o_dbus_adr,
   output logic [`CORE_XLEN-1:0] o_dbus_dat,
   output logic                  o_dbus_cyc,
   input  logic                  i_dbus_ack
);

   logic               fetch;
   logic [4:0]         cnt;
   logic               cnt_en;
   logic               alu_init;
   ctrl_pkg::alu_op_e  alu_op;
   logic               op_b_imm;
   logic               imm;
   isa_pkg::reg_addr_t rs1_addr;
   isa_pkg::reg_addr_t rs2_addr;
   isa_pkg::reg_addr_t rd_addr;
   logic               rd_we;
   logic               store_en;
   logic               store_done;
   logic               rs1;
   logic               rs2;
   logic               op_b;
   logic               alu_rd;

   // Operand B is the immediate or rs2
   assign op_b = op_b_imm ? imm : rs2;

   instr_decode u_decode (
      .clk          (clk),
      .i_rst_n      (i_rst_n),
      .i_ibus_rdt   (i_ibus_rdt),
      .i_ibus_ack   (i_ibus_ack),
      .i_store_done (store_done),
      .o_fetch      (fetch),
      .o_cnt        (cnt),
      .o_cnt_en     (cnt_en),
      .o_alu_init   (alu_init),
      .o_alu_op     (alu_op),
      .o_op_b_imm   (op_b_imm),
      .o_imm        (imm),
      .o_rs1_addr   (rs1_addr),
      .o_rs2_addr   (rs2_addr),
      .o_rd_addr    (rd_addr),
      .o_rd_we      (rd_we),
      .o_store_en   (store_en)
   );

   serial_alu u_alu (
      .clk      (clk),
      .i_rst_n  (i_rst_n),
      .i_cnt_en (cnt_en),
      .i_init   (alu_init),
      .i_op     (alu_op),
      .i_rs1    (rs1),
      .i_op_b   (op_b),
      .o_rd     (alu_rd)
   );

   reg_file u_regs (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_cnt      (cnt),
      .i_cnt_en   (cnt_en),
      .i_rs1_addr (rs1_addr),
      .i_rs2_addr (rs2_addr),
      .i_rd_addr  (rd_addr),
      .i_rd_we    (rd_we),
      .i_rd       (alu_rd),
      .o_rs1      (rs1),
      .o_rs2      (rs2)
   );

   pc_ctrl u_pc (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_cnt      (cnt),
      .i_cnt_en   (cnt_en),
      .i_fetch    (fetch),
      .i_ibus_ack (i_ibus_ack),
      .o_ibus_adr (o_ibus_adr),
      .o_ibus_cyc (o_ibus_cyc)
   );

   // The ALU sum is the store address
   store_unit u_store (
      .clk          (clk),
      .i_rst_n      (i_rst_n),
      .i_cnt_en     (cnt_en),
      .i_store_en   (store_en),
      .i_addr_bit   (alu_rd),
      .i_data_bit   (rs2),
      .i_dbus_ack   (i_dbus_ack),
      .o_dbus_adr   (o_dbus_adr),
      .o_dbus_dat   (o_dbus_dat),
      .o_dbus_cyc   (o_dbus_cyc),
      .o_store_done (store_done)
   );

endmodule

// File: src/core_defines.svh
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// Address of the first instruction fetch
`define CORE_RESET_PC 32'h0000_0000

// Data path and register width
`define CORE_XLEN 32

// Number of architectural registers
`define CORE_NREGS 32

`endif

// File: src/ctrl_pkg.sv
package ctrl_pkg;

   // Instruction sequencer
   typedef enum logic [1:0] {
      S_FETCH  = 2'd0,
      S_DECODE = 2'd1,
      S_EXEC   = 2'd2,
      S_STORE  = 2'd3
   } seq_state_e;

   // Per-bit ALU operation
   typedef enum logic [2:0] {
      ALU_ADD   = 3'd0,
      ALU_SUB   = 3'd1,
      ALU_XOR   = 3'd2,
      ALU_OR    = 3'd3,
      ALU_AND   = 3'd4,
      ALU_PASSB = 3'd5
   } alu_op_e;

endpackage

// File: src/instr_decode.sv
`timescale 1ns/100ps
`include "core_defines.svh"

module instr_decode (
   input  logic                clk,
   input  logic                i_rst_n,
   input  logic [31:0]         i_ibus_rdt,
   input  logic                i_ibus_ack,
   input  logic                i_store_done,
   output logic                o_fetch,
   output logic [4:0]          o_cnt,
   output logic                o_cnt_en,
   output logic                o_alu_init,
   output ctrl_pkg::alu_op_e   o_alu_op,
   output logic                o_op_b_imm,
   output logic                o_imm,
   output isa_pkg::reg_addr_t  o_rs1_addr,
   output isa_pkg::reg_addr_t  o_rs2_addr,
   output isa_pkg::reg_addr_t  o_rd_addr,
   output logic                o_rd_we,
   output logic                o_store_en
);

   ctrl_pkg::seq_state_e  state;
   logic [31:0]           ir;
   logic [`CORE_XLEN-1:0] imm_word;
   isa_pkg::opcode_e      opcode;
   isa_pkg::funct3_e      funct3;
   isa_pkg::funct7_t      funct7;
   logic                  is_sw;

   assign opcode = isa_pkg::opcode_e'(ir[6:0]);
   assign funct3 = isa_pkg::funct3_e'(ir[14:12]);
   assign funct7 = ir[31:25];

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         state <= ctrl_pkg::S_FETCH;
         o_cnt <= 5'd0;
      end else begin
         case (state)
            ctrl_pkg::S_FETCH:
               if (i_ibus_ack) state <= ctrl_pkg::S_DECODE;
            ctrl_pkg::S_DECODE: begin
               o_cnt <= 5'd0;
               state <= ctrl_pkg::S_EXEC;
            end
            ctrl_pkg::S_EXEC: begin
               o_cnt <= o_cnt + 5'd1;
               // Last bit, stores go on to the data bus
               if (o_cnt == 5'd31)
                  state <= is_sw ? ctrl_pkg::S_STORE : ctrl_pkg::S_FETCH;
            end
            default:
               if (i_store_done) state <= ctrl_pkg::S_FETCH;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == ctrl_pkg::S_FETCH && i_ibus_ack) ir <= i_ibus_rdt;
   end

   always_comb begin
      o_alu_op   = ctrl_pkg::ALU_ADD;
      o_op_b_imm = 1'b0;
      o_rd_we    = 1'b0;
      is_sw      = 1'b0;
      imm_word   = {{20{ir[31]}}, ir[31:20]};
      case (opcode)
         isa_pkg::OP_LUI: begin
            o_alu_op   = ctrl_pkg::ALU_PASSB;
            o_op_b_imm = 1'b1;
            o_rd_we    = 1'b1;
            imm_word   = {ir[31:12], 12'b0};
         end
         isa_pkg::OP_IMM: begin
            o_op_b_imm = 1'b1;
            o_rd_we    = 1'b1;
            case (funct3)
               isa_pkg::F3_ADD: o_alu_op = ctrl_pkg::ALU_ADD;
               isa_pkg::F3_XOR: o_alu_op = ctrl_pkg::ALU_XOR;
               isa_pkg::F3_OR:  o_alu_op = ctrl_pkg::ALU_OR;
               isa_pkg::F3_AND: o_alu_op = ctrl_pkg::ALU_AND;
               default:         o_rd_we  = 1'b0;
            endcase
         end
         isa_pkg::OP_REG: begin
            case (funct3)
               isa_pkg::F3_ADD: begin
                  o_alu_op = ir[30] ? ctrl_pkg::ALU_SUB : ctrl_pkg::ALU_ADD;
                  o_rd_we  = (funct7 == isa_pkg::F7_BASE) || (funct7 == isa_pkg::F7_SUB);
               end
               isa_pkg::F3_XOR: begin
                  o_alu_op = ctrl_pkg::ALU_XOR;
                  o_rd_we  = (funct7 == isa_pkg::F7_BASE);
               end
               isa_pkg::F3_OR: begin
                  o_alu_op = ctrl_pkg::ALU_OR;
                  o_rd_we  = (funct7 == isa_pkg::F7_BASE);
               end
               isa_pkg::F3_AND: begin
                  o_alu_op = ctrl_pkg::ALU_AND;
                  o_rd_we  = (funct7 == isa_pkg::F7_BASE);
               end
               default: o_rd_we = 1'b0;
            endcase
         end
         isa_pkg::OP_STORE: begin
            // Address is rs1 + S immediate
            o_op_b_imm = 1'b1;
            is_sw      = (funct3 == isa_pkg::F3_SW);
            imm_word   = {{20{ir[31]}}, ir[31:25], ir[11:7]};
         end
         default: o_rd_we = 1'b0;
      endcase
   end

   assign o_fetch    = (state == ctrl_pkg::S_FETCH);
   assign o_cnt_en   = (state == ctrl_pkg::S_EXEC);
   assign o_alu_init = o_cnt_en && (o_cnt == 5'd0);
   assign o_imm      = imm_word[o_cnt];
   assign o_store_en = is_sw;
   assign o_rs1_addr = ir[19:15];
   assign o_rs2_addr = ir[24:20];
   assign o_rd_addr  = ir[11:7];

endmodule

// File: src/isa_pkg.sv
package isa_pkg;

   // Major opcodes handled by the core
   typedef enum logic [6:0] {
      OP_LUI   = 7'b0110111,
      OP_IMM   = 7'b0010011,
      OP_REG   = 7'b0110011,
      OP_STORE = 7'b0100011
   } opcode_e;

   // funct3 codes, SW shares the space with the ALU codes
   typedef enum logic [2:0] {
      F3_ADD = 3'b000,
      F3_SW  = 3'b010,
      F3_XOR = 3'b100,
      F3_OR  = 3'b110,
      F3_AND = 3'b111
   } funct3_e;

   // Register index
   typedef logic [4:0] reg_addr_t;

   // Upper funct field of R-type words
   typedef logic [6:0] funct7_t;

   localparam funct7_t F7_BASE = 7'b0000000;
   localparam funct7_t F7_SUB  = 7'b0100000;

endpackage

// File: src/pc_ctrl.sv
`timescale 1ns/100ps
`include "core_defines.svh"

module pc_ctrl (
   input  logic                  clk,
   input  logic                  i_rst_n,
   input  logic [4:0]            i_cnt,
   input  logic                  i_cnt_en,
   input  logic                  i_fetch,
   input  logic                  i_ibus_ack,
   output logic [`CORE_XLEN-1:0] o_ibus_adr,
   output logic                  o_ibus_cyc
);

   logic [`CORE_XLEN-1:0] pc;
   logic                  carry;
   logic                  ack_done;
   logic                  inc_bit;
   logic                  c_in;
   logic                  sum;

   // Constant 4 fed in one bit at a time
   assign inc_bit = (i_cnt == 5'd2);
   assign c_in    = (i_cnt == 5'd0) ? 1'b0 : carry;
   assign sum     = pc[0] ^ inc_bit ^ c_in;

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         pc    <= `CORE_RESET_PC;
         carry <= 1'b0;
      end else if (i_cnt_en) begin
         pc    <= {sum, pc[`CORE_XLEN-1:1]};
         carry <= (pc[0] & inc_bit) | (c_in & (pc[0] ^ inc_bit));
      end
   end

   // One request per fetch phase
   always_ff @(posedge clk) begin
      if (!i_rst_n || !i_fetch) begin
         ack_done <= 1'b0;
      end else if (o_ibus_cyc && i_ibus_ack) begin
         ack_done <= 1'b1;
      end
   end

   assign o_ibus_cyc = i_fetch && !ack_done;
   assign o_ibus_adr = pc;

endmodule

// File: src/reg_file.sv
`timescale 1ns/100ps
`include "core_defines.svh"

module reg_file (
   input  logic               clk,
   input  logic               i_rst_n,
   input  logic [4:0]         i_cnt,
   input  logic               i_cnt_en,
   input  isa_pkg::reg_addr_t i_rs1_addr,
   input  isa_pkg::reg_addr_t i_rs2_addr,
   input  isa_pkg::reg_addr_t i_rd_addr,
   input  logic               i_rd_we,
   input  logic               i_rd,
   output logic               o_rs1,
   output logic               o_rs2
);

   logic [`CORE_XLEN-1:0] regs [`CORE_NREGS];
   logic                  wr_en;

   // x0 never takes a write so it stays at its reset value
   assign wr_en = i_rd_we && i_cnt_en && (i_rd_addr != 5'd0);

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         for (int i = 0; i < `CORE_NREGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en) begin
         regs[i_rd_addr][i_cnt] <= i_rd;
      end
   end

   // Each bit is read before the same bit of rd is written,
   // so rd may equal rs1 or rs2
   assign o_rs1 = regs[i_rs1_addr][i_cnt];
   assign o_rs2 = regs[i_rs2_addr][i_cnt];

endmodule

// File: src/serial_alu.sv
`timescale 1ns/100ps

module serial_alu (
   input  logic              clk,
   input  logic              i_rst_n,
   input  logic              i_cnt_en,
   input  logic              i_init,
   input  ctrl_pkg::alu_op_e i_op,
   input  logic              i_rs1,
   input  logic              i_op_b,
   output logic              o_rd
);

   logic carry;
   logic c_in;
   logic b_eff;
   logic sum;
   logic c_out;

   // Subtract as rs1 + ~b + 1, the +1 comes from the preset carry
   assign b_eff = (i_op == ctrl_pkg::ALU_SUB) ? ~i_op_b : i_op_b;
   assign c_in  = i_init ? (i_op == ctrl_pkg::ALU_SUB) : carry;
   assign sum   = i_rs1 ^ b_eff ^ c_in;
   assign c_out = (i_rs1 & b_eff) | (c_in & (i_rs1 ^ b_eff));

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         carry <= 1'b0;
      end else if (i_cnt_en) begin
         carry <= c_out;
      end
   end

   always_comb begin
      case (i_op)
         ctrl_pkg::ALU_ADD,
         ctrl_pkg::ALU_SUB:   o_rd = sum;
         ctrl_pkg::ALU_XOR:   o_rd = i_rs1 ^ i_op_b;
         ctrl_pkg::ALU_OR:    o_rd = i_rs1 | i_op_b;
         ctrl_pkg::ALU_AND:   o_rd = i_rs1 & i_op_b;
         ctrl_pkg::ALU_PASSB: o_rd = i_op_b;
         default:             o_rd = 1'b0;
      endcase
   end

endmodule

// File: src/store_unit.sv
`timescale 1ns/100ps
`include "core_defines.svh"

module store_unit (
   input  logic                  clk,
   input  logic                  i_rst_n,
   input  logic                  i_cnt_en,
   input  logic                  i_store_en,
   input  logic                  i_addr_bit,
   input  logic                  i_data_bit,
   input  logic                  i_dbus_ack,
   output logic [`CORE_XLEN-1:0] o_dbus_adr,
   output logic [`CORE_XLEN-1:0] o_dbus_dat,
   output logic                  o_dbus_cyc,
   output logic                  o_store_done
);

   logic [`CORE_XLEN-1:0] adr_sr;
   logic [`CORE_XLEN-1:0] dat_sr;
   logic                  pending;
   logic                  shift_en;

   assign shift_en = i_cnt_en && i_store_en;

   // LSB enters first and ends up at bit 0
   always_ff @(posedge clk) begin
      if (shift_en) begin
         adr_sr <= {i_addr_bit, adr_sr[`CORE_XLEN-1:1]};
         dat_sr <= {i_data_bit, dat_sr[`CORE_XLEN-1:1]};
      end
   end

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         pending <= 1'b0;
      end else if (o_store_done) begin
         pending <= 1'b0;
      end else if (shift_en) begin
         pending <= 1'b1;
      end
   end

   // Request starts once the word is complete
   assign o_dbus_cyc   = pending && !i_cnt_en;
   assign o_store_done = o_dbus_cyc && i_dbus_ack;
   assign o_dbus_adr   = {adr_sr[`CORE_XLEN-1:2], 2'b00};
   assign o_dbus_dat   = dat_sr;

endmodule
